// File: core_pkg.sv
// core widths, reset pc, opcode and operation enums, stage link structs
package core_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int INST_W    = 32;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  typedef logic [XLEN-1:0]      xdata_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // rv32i major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // decoded operation handed to execute
  typedef enum logic [3:0] {
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_LUI,
    OP_JAL,
    OP_BEQ,
    OP_BNE,
    OP_ILLEGAL
  } op_e;

  typedef struct packed {
    xdata_t              pc;
    logic [INST_W-1:0]   inst;
  } if_id_t;

  typedef struct packed {
    xdata_t              pc;
    logic [INST_W-1:0]   inst;
    op_e                 op;
    xdata_t              op1;
    xdata_t              op2;
    xdata_t              imm;
    reg_idx_t            rd;
    logic                rd_wen;
  } id_ex_t;

  typedef struct packed {
    xdata_t              pc;
    logic [INST_W-1:0]   inst;
    reg_idx_t            rd;
    logic                rd_wen;
    xdata_t              wdata;
  } ex_wb_t;

  // retired instruction record at the core boundary
  typedef struct packed {
    xdata_t              pc;
    logic [INST_W-1:0]   inst;
    reg_idx_t            rd;
    logic                rd_wen;
    xdata_t              wdata;
  } commit_t;

  typedef struct packed {
    logic                taken;
    xdata_t              target;
  } redirect_t;

endpackage

// File: regfile.sv
// integer register file, two combinational reads and one write, x0 tied to zero
module regfile (
  input  logic              clk,
  input  logic              i_rst_n,
  input  core_pkg::reg_idx_t i_rs1,
  input  core_pkg::reg_idx_t i_rs2,
  output core_pkg::xdata_t   o_rs1_data,
  output core_pkg::xdata_t   o_rs2_data,
  input  core_pkg::reg_idx_t i_rd,
  input  logic              i_rd_wen,
  input  core_pkg::xdata_t   i_rd_wdata
);

  core_pkg::xdata_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: fetch_stage.sv
// program counter, single outstanding instruction bus request, redirect on retire
module fetch_stage (
  input  logic                        clk,
  input  logic                        i_rst_n,
  input  logic                        i_retired,
  input  core_pkg::redirect_t         i_redirect,
  output logic                        o_ibus_req,
  output core_pkg::xdata_t            o_ibus_addr,
  input  logic                        i_ibus_ack,
  input  logic [core_pkg::INST_W-1:0] i_ibus_rdata,
  output logic                        o_fetched,
  output core_pkg::if_id_t            o_if_id
);

  typedef enum logic [1:0] {
    S_START,
    S_REQ,
    S_WAIT
  } state_e;

  state_e           state;
  core_pkg::xdata_t pc;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state      <= S_START;
      pc         <= core_pkg::RESET_PC;
      o_ibus_req <= 1'b0;
      o_fetched  <= 1'b0;
    end else begin
      o_fetched <= 1'b0;
      unique case (state)
        S_START: begin
          o_ibus_req <= 1'b1;
          state      <= S_REQ;
        end
        S_REQ: begin
          if (i_ibus_ack) begin
            o_ibus_req <= 1'b0;
            o_fetched  <= 1'b1;
            state      <= S_WAIT;
          end
        end
        S_WAIT: begin
          // next pc once the current instruction has retired
          if (i_retired) begin
            pc         <= i_redirect.taken ? i_redirect.target : pc + 32'd4;
            o_ibus_req <= 1'b1;
            state      <= S_REQ;
          end
        end
        default: state <= S_START;
      endcase
    end
  end

  // instruction latch
  always_ff @(posedge clk) begin
    if (state == S_REQ && i_ibus_ack) begin
      o_if_id.pc   <= pc;
      o_if_id.inst <= i_ibus_rdata;
    end
  end

  assign o_ibus_addr = pc;

endmodule

// File: decode_stage.sv
// instruction decode, immediate generation and register operand read
module decode_stage (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_fetched,
  input  core_pkg::if_id_t   i_if_id,
  output core_pkg::reg_idx_t o_rs1,
  output core_pkg::reg_idx_t o_rs2,
  input  core_pkg::xdata_t   i_rs1_data,
  input  core_pkg::xdata_t   i_rs2_data,
  output logic               o_decoded,
  output core_pkg::id_ex_t   o_id_ex
);

  logic [core_pkg::INST_W-1:0] inst;
  logic [2:0]                  funct3;
  logic [6:0]                  funct7;
  core_pkg::xdata_t            imm_i;
  core_pkg::xdata_t            imm_u;
  core_pkg::xdata_t            imm_j;
  core_pkg::xdata_t            imm_b;
  core_pkg::op_e               op;
  core_pkg::xdata_t            imm;
  logic                        rd_wen;

  assign inst   = i_if_id.inst;
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  assign o_rs1 = inst[19:15];
  assign o_rs2 = inst[24:20];

  always_comb begin
    op = core_pkg::OP_ILLEGAL;
    case (inst[6:0])
      core_pkg::OPC_OP_IMM: begin
        if (funct3 == 3'b000) op = core_pkg::OP_ADDI;
      end
      core_pkg::OPC_OP: begin
        if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = core_pkg::OP_SUB;
        end else if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = core_pkg::OP_ADD;
            3'b010:  op = core_pkg::OP_SLT;
            3'b100:  op = core_pkg::OP_XOR;
            3'b110:  op = core_pkg::OP_OR;
            3'b111:  op = core_pkg::OP_AND;
            default: op = core_pkg::OP_ILLEGAL;
          endcase
        end
      end
      core_pkg::OPC_LUI: op = core_pkg::OP_LUI;
      core_pkg::OPC_JAL: op = core_pkg::OP_JAL;
      core_pkg::OPC_BRANCH: begin
        if (funct3 == 3'b000) op = core_pkg::OP_BEQ;
        else if (funct3 == 3'b001) op = core_pkg::OP_BNE;
      end
      default: op = core_pkg::OP_ILLEGAL;
    endcase
  end

  // immediate format and register write enable per operation
  always_comb begin
    imm    = '0;
    rd_wen = 1'b0;
    case (op)
      core_pkg::OP_ADDI: begin
        imm    = imm_i;
        rd_wen = 1'b1;
      end
      core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
      core_pkg::OP_OR, core_pkg::OP_XOR, core_pkg::OP_SLT: begin
        rd_wen = 1'b1;
      end
      core_pkg::OP_LUI: begin
        imm    = imm_u;
        rd_wen = 1'b1;
      end
      core_pkg::OP_JAL: begin
        imm    = imm_j;
        rd_wen = 1'b1;
      end
      core_pkg::OP_BEQ, core_pkg::OP_BNE: imm = imm_b;
      default: rd_wen = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_decoded <= 1'b0;
    end else begin
      o_decoded <= i_fetched;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      o_id_ex.pc     <= i_if_id.pc;
      o_id_ex.inst   <= inst;
      o_id_ex.op     <= op;
      o_id_ex.op1    <= i_rs1_data;
      o_id_ex.op2    <= i_rs2_data;
      o_id_ex.imm    <= imm;
      o_id_ex.rd     <= inst[11:7];
      o_id_ex.rd_wen <= rd_wen;
    end
  end

endmodule

// File: exec_stage.sv
// alu, branch decision and jump target computation
module exec_stage (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_decoded,
  input  core_pkg::id_ex_t    i_id_ex,
  output logic                o_executed,
  output core_pkg::ex_wb_t    o_ex_wb,
  output core_pkg::redirect_t o_redirect
);

  core_pkg::xdata_t result;
  core_pkg::xdata_t target;
  logic             taken;
  logic             less;

  assign less   = $signed(i_id_ex.op1) < $signed(i_id_ex.op2);
  assign target = i_id_ex.pc + i_id_ex.imm;

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (i_id_ex.op)
      core_pkg::OP_ADDI: result = i_id_ex.op1 + i_id_ex.imm;
      core_pkg::OP_ADD:  result = i_id_ex.op1 + i_id_ex.op2;
      core_pkg::OP_SUB:  result = i_id_ex.op1 - i_id_ex.op2;
      core_pkg::OP_AND:  result = i_id_ex.op1 & i_id_ex.op2;
      core_pkg::OP_OR:   result = i_id_ex.op1 | i_id_ex.op2;
      core_pkg::OP_XOR:  result = i_id_ex.op1 ^ i_id_ex.op2;
      core_pkg::OP_SLT:  result = {31'b0, less};
      core_pkg::OP_LUI:  result = i_id_ex.imm;
      core_pkg::OP_JAL: begin
        // link address
        result = i_id_ex.pc + 32'd4;
        taken  = 1'b1;
      end
      core_pkg::OP_BEQ:  taken = (i_id_ex.op1 == i_id_ex.op2);
      core_pkg::OP_BNE:  taken = (i_id_ex.op1 != i_id_ex.op2);
      default:           result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_executed       <= 1'b0;
      o_redirect.taken <= 1'b0;
    end else begin
      o_executed <= i_decoded;
      if (i_decoded) o_redirect.taken <= taken;
    end
  end

  // held until fetch consumes it on retire
  always_ff @(posedge clk) begin
    if (i_decoded) begin
      o_redirect.target <= target;
      o_ex_wb.pc        <= i_id_ex.pc;
      o_ex_wb.inst      <= i_id_ex.inst;
      o_ex_wb.rd        <= i_id_ex.rd;
      o_ex_wb.rd_wen    <= i_id_ex.rd_wen;
      o_ex_wb.wdata     <= result;
    end
  end

endmodule

// File: writeback_stage.sv
// register write port drive, retire pulse and commit record
module writeback_stage (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_executed,
  input  core_pkg::ex_wb_t   i_ex_wb,
  output core_pkg::reg_idx_t o_rd,
  output logic               o_rd_wen,
  output core_pkg::xdata_t   o_rd_wdata,
  output logic               o_retired,
  output logic               o_commit_valid,
  output core_pkg::commit_t  o_commit
);

  // write lands on the same edge that raises commit
  assign o_rd       = i_ex_wb.rd;
  assign o_rd_wen   = i_executed & i_ex_wb.rd_wen;
  assign o_rd_wdata = i_ex_wb.wdata;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_retired      <= 1'b0;
      o_commit_valid <= 1'b0;
    end else begin
      o_retired      <= i_executed;
      o_commit_valid <= i_executed;
    end
  end

  always_ff @(posedge clk) begin
    if (i_executed) begin
      o_commit.pc     <= i_ex_wb.pc;
      o_commit.inst   <= i_ex_wb.inst;
      o_commit.rd     <= i_ex_wb.rd;
      o_commit.rd_wen <= i_ex_wb.rd_wen;
      o_commit.wdata  <= i_ex_wb.wdata;
    end
  end

endmodule

// File: core_top.sv
// core top level, stage instances and register file
module core_top (
  input  logic                        clk,
  input  logic                        i_rst_n,
  output logic                        o_ibus_req,
  output core_pkg::xdata_t            o_ibus_addr,
  input  logic                        i_ibus_ack,
  input  logic [core_pkg::INST_W-1:0] i_ibus_rdata,
  output logic                        o_commit_valid,
  output core_pkg::commit_t           o_commit
);

  // stage handshake pulses
  logic fetched;
  logic decoded;
  logic executed;
  logic retired;

  core_pkg::if_id_t    if_id;
  core_pkg::id_ex_t    id_ex;
  core_pkg::ex_wb_t    ex_wb;
  core_pkg::redirect_t redirect;

  core_pkg::reg_idx_t  rs1;
  core_pkg::reg_idx_t  rs2;
  core_pkg::xdata_t    rs1_data;
  core_pkg::xdata_t    rs2_data;
  core_pkg::reg_idx_t  rd;
  logic                rd_wen;
  core_pkg::xdata_t    rd_wdata;

  fetch_stage i_fetch_stage (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_retired    (retired),
    .i_redirect   (redirect),
    .o_ibus_req   (o_ibus_req),
    .o_ibus_addr  (o_ibus_addr),
    .i_ibus_ack   (i_ibus_ack),
    .i_ibus_rdata (i_ibus_rdata),
    .o_fetched    (fetched),
    .o_if_id      (if_id)
  );

  decode_stage i_decode_stage (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_fetched  (fetched),
    .i_if_id    (if_id),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_decoded  (decoded),
    .o_id_ex    (id_ex)
  );

  exec_stage i_exec_stage (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_decoded  (decoded),
    .i_id_ex    (id_ex),
    .o_executed (executed),
    .o_ex_wb    (ex_wb),
    .o_redirect (redirect)
  );

  writeback_stage i_writeback_stage (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_executed     (executed),
    .i_ex_wb        (ex_wb),
    .o_rd           (rd),
    .o_rd_wen       (rd_wen),
    .o_rd_wdata     (rd_wdata),
    .o_retired      (retired),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit)
  );

  regfile i_regfile (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_rd       (rd),
    .i_rd_wen   (rd_wen),
    .i_rd_wdata (rd_wdata)
  );

endmodule

// File: tb_clock.sv
// testbench clock and synchronous reset generator
module tb_clock (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // reset held low over four rising edges and released on a falling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (4) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// File: tb_core.sv
// core testbench with instruction memory model, reference model, compare tasks and directed tests
module tb_core;
  timeunit 1ns;
  timeprecision 100ps;

  // about 40 instructions at up to 10 cycles each plus reset
  localparam int TIMEOUT_CYCLES = 500;

  logic                        clk;
  logic                        rst_n;
  logic                        o_ibus_req;
  core_pkg::xdata_t            o_ibus_addr;
  logic                        i_ibus_ack = 1'b0;
  logic [core_pkg::INST_W-1:0] i_ibus_rdata = '0;
  logic                        o_commit_valid;
  core_pkg::commit_t           o_commit;

  // a word is only returned once a test has loaded it
  logic [31:0]      imem [0:63];
  logic [63:0]      imem_valid = '0;
  core_pkg::xdata_t load_end = core_pkg::RESET_PC;
  core_pkg::xdata_t ref_pc = core_pkg::RESET_PC;
  core_pkg::xdata_t ref_regs [0:31];
  int               seed = 1;
  int               mem_delay = 0;
  logic             mem_busy = 1'b0;
  int               cycles = 0;
  int               errors = 0;
  int               tests_run = 0;
  int               tests_failed = 0;

  tb_clock i_tb_clock (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  core_top i_core_top (
    .clk            (clk),
    .i_rst_n        (rst_n),
    .o_ibus_req     (o_ibus_req),
    .o_ibus_addr    (o_ibus_addr),
    .i_ibus_ack     (i_ibus_ack),
    .i_ibus_rdata   (i_ibus_rdata),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit)
  );

  // instruction bus responder with a random latency of 0 to 3 cycles
  always @(negedge clk) begin
    if (i_ibus_ack) begin
      i_ibus_ack <= 1'b0;
    end else if (rst_n && o_ibus_req) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_delay = {$random(seed)} % 4;
      end
      if (mem_delay > 0) begin
        mem_delay = mem_delay - 1;
      end else if (o_ibus_addr < 32'd256 && imem_valid[o_ibus_addr[7:2]]) begin
        i_ibus_ack   <= 1'b1;
        i_ibus_rdata <= imem[o_ibus_addr[7:2]];
        mem_busy = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
    return {imm, rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input int rs1,
                                             input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[load_end[7:2]] = word;
    imem_valid[load_end[7:2]] = 1'b1;
    load_end = load_end + 32'd4;
  endtask

  // rv32i semantics of the instruction at ref_pc, updates the register model
  task automatic predict(output core_pkg::commit_t exp, output core_pkg::xdata_t nxt);
    logic [31:0]      inst;
    core_pkg::xdata_t a;
    core_pkg::xdata_t b;
    core_pkg::xdata_t res;
    logic             wr;
    inst = imem[ref_pc[7:2]];
    a = ref_regs[inst[19:15]];
    b = ref_regs[inst[24:20]];
    res = '0;
    wr = 1'b1;
    nxt = ref_pc + 32'd4;
    case (inst[6:0])
      7'b0010011: begin
        if (inst[14:12] == 3'b000) res = a + {{20{inst[31]}}, inst[31:20]};
        else wr = 1'b0;
      end
      7'b0110011: begin
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_111: res = a & b;
          10'b0000000_110: res = a | b;
          10'b0000000_100: res = a ^ b;
          10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: wr = 1'b0;
        endcase
      end
      7'b0110111: res = {inst[31:12], 12'h000};
      7'b1101111: begin
        res = ref_pc + 32'd4;
        nxt = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'b1100011: begin
        wr = 1'b0;
        if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b)) begin
          nxt = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      default: wr = 1'b0;
    endcase
    exp.pc = ref_pc;
    exp.inst = inst;
    exp.rd = inst[11:7];
    exp.rd_wen = wr;
    exp.wdata = res;
    if (wr && inst[11:7] != 5'd0) ref_regs[inst[11:7]] = res;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("mismatch %s got %h expected %h", name, got, exp);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic check_commit(input core_pkg::commit_t got, input core_pkg::commit_t exp);
    if (got.pc !== exp.pc) report_mismatch("o_commit.pc", got.pc, exp.pc);
    if (got.inst !== exp.inst) report_mismatch("o_commit.inst", got.inst, exp.inst);
    if (got.rd_wen !== exp.rd_wen) report_mismatch("o_commit.rd_wen", 32'(got.rd_wen),
                                                   32'(exp.rd_wen));
    // rd and wdata only carry meaning for a register write
    if (exp.rd_wen) begin
      if (got.rd !== exp.rd) report_mismatch("o_commit.rd", 32'(got.rd), 32'(exp.rd));
      if (got.wdata !== exp.wdata) report_mismatch("o_commit.wdata", got.wdata, exp.wdata);
    end
  endtask

  task automatic check_addr(input core_pkg::xdata_t got, input core_pkg::xdata_t exp);
    if (got !== exp) report_mismatch("o_ibus_addr", got, exp);
  endtask

  task automatic wait_commit();
    do begin
      @(negedge clk);
    end while (o_commit_valid !== 1'b1);
  endtask

  // commit must stay low until the next request shows up
  task automatic wait_fetch();
    do begin
      @(negedge clk);
      if (o_commit_valid !== 1'b0) report_error("commit valid high while waiting for a fetch");
    end while (o_ibus_req !== 1'b1);
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  // follows the commits until the reference reaches the end of the loaded code
  task automatic run_program(input string name);
    int                err0;
    core_pkg::commit_t exp;
    core_pkg::xdata_t  nxt;
    err0 = errors;
    while (ref_pc != load_end) begin
      wait_commit();
      predict(exp, nxt);
      check_commit(o_commit, exp);
      ref_pc = nxt;
      wait_fetch();
      check_addr(o_ibus_addr, ref_pc);
    end
    finish_test(name, err0);
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      if (o_commit_valid !== 1'b0) report_error("commit valid high during reset");
    end
    wait_fetch();
    check_addr(o_ibus_addr, core_pkg::RESET_PC);
    finish_test("reset", err0);
  endtask

  task automatic test_arith();
    emit(enc_addi(1, 0, 100));
    emit(enc_addi(2, 0, -7));
    emit(enc_r(7'h00, 3'b000, 3, 1, 2));
    emit(enc_r(7'h20, 3'b000, 4, 1, 2));
    emit(enc_lui(5, 20'h12345));
    emit(enc_addi(7, 5, 1656));
    // reads back earlier results
    emit(enc_r(7'h00, 3'b000, 6, 7, 3));
    run_program("arith");
  endtask

  task automatic test_logic();
    emit(enc_addi(8, 0, 1445));
    emit(enc_addi(9, 0, -256));
    emit(enc_r(7'h00, 3'b111, 10, 8, 9));
    emit(enc_r(7'h00, 3'b110, 11, 8, 9));
    emit(enc_r(7'h00, 3'b100, 12, 8, 9));
    emit(enc_r(7'h00, 3'b010, 13, 9, 8));
    emit(enc_r(7'h00, 3'b010, 14, 8, 9));
    emit(enc_r(7'h00, 3'b010, 15, 9, 9));
    run_program("logic");
  endtask

  task automatic test_x0();
    emit(enc_addi(0, 0, 123));
    emit(enc_r(7'h00, 3'b000, 16, 0, 8));
    emit(enc_r(7'h00, 3'b000, 17, 8, 0));
    run_program("x0");
  endtask

  task automatic test_branch();
    emit(enc_addi(1, 0, 5));
    emit(enc_addi(2, 0, 5));
    emit(enc_jal(3, 8));
    emit(enc_addi(4, 0, 1));
    emit(enc_branch(3'b000, 1, 2, 8));
    emit(enc_addi(4, 0, 2));
    emit(enc_branch(3'b001, 1, 0, 8));
    emit(enc_addi(4, 0, 3));
    // both fall through
    emit(enc_branch(3'b000, 1, 0, 8));
    emit(enc_branch(3'b001, 1, 2, 8));
    emit(enc_addi(20, 4, 7));
    run_program("branch");
  endtask

  task automatic test_illegal();
    emit(enc_addi(18, 0, 42));
    // sll and ecall are outside the subset
    emit(enc_r(7'h00, 3'b001, 18, 1, 2));
    emit(32'h0000_0073);
    emit(enc_addi(19, 18, 1));
    run_program("illegal");
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    test_reset();
    test_arith();
    test_logic();
    test_x0();
    test_branch();
    test_illegal();
    $display("tests %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
core_pkg.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
exec_stage.sv
writeback_stage.sv
core_top.sv
tb_clock.sv
tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_core -f vlog.f -o tb_core_sim

./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
